/* list.f */
ucode_pkg.sv
iram_port_if.sv
iram.sv
ucode_loader.sv
usequencer.sv
ucode_top.sv
tb_ucode_top.sv

/* tb_ucode_top.sv */
/* Testbench for the microcode store and fetch unit.
   Loads microcode over Wishbone, runs programs and checks every shown word. */

module tb_ucode_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        arst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [3:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        run;
   logic        cond;
   logic [3:0]  disp_key;
   logic [48:0] ir;
   logic        ir_valid;
   logic [13:0] pc;
   logic        running;
   logic [4:0]  alu_fn;
   logic [11:0] dest;

   // Mirror of the loaded microcode.
   logic [48:0] ref_mem [16384];
   // Expected shown addresses and words of the current run.
   logic [13:0] exp_addr [$];
   logic [48:0] exp_word [$];
   int          seed = 48;
   int          cycles = 0;

   ucode_top #(
      .MEM_DEPTH (16384)
   ) ucode_top_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .run      (run),
      .cond     (cond),
      .disp_key (disp_key),
      .ir       (ir),
      .ir_valid (ir_valid),
      .pc       (pc),
      .running  (running),
      .alu_fn   (alu_fn),
      .dest     (dest)
   );

   // 4 ns clock.
   always #2 clk = ~clk;

   ////////////////////////////////////////
   // Failure reporting and checks.
   ////////////////////////////////////////

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                        input string what);
      if (actual !== expected) begin
         report_failure($sformatf("mismatch at %0d ns: %s got %h expected %h",
                                  $time, what, actual, expected));
      end
   endtask

   // Run limit.
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         report_failure("timeout: the tests did not finish within the cycle limit");
      end
   end

   ////////////////////////////////////////
   // Wishbone master tasks.
   ////////////////////////////////////////

   task automatic wb_write(input logic [1:0] reg_off, input logic [31:0] data);
      @(posedge clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = {reg_off, 2'b00};
      wb_dat_w = data;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      // Master drops stb after the single ack cycle.
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input logic [1:0] reg_off, output logic [31:0] data);
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = {reg_off, 2'b00};
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      data = wb_dat_r;
      @(posedge clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // Low half then high half; the address steps after the high half.
   task automatic write_data(input logic [48:0] w);
      wb_write(ucode_pkg::REG_DATA_LO, w[31:0]);
      wb_write(ucode_pkg::REG_DATA_HI, {15'd0, w[48:32]});
   endtask

   task automatic load_word(input logic [13:0] addr, input logic [48:0] w);
      wb_write(ucode_pkg::REG_ADDR, {18'd0, addr});
      write_data(w);
      ref_mem[addr] = w;
   endtask

   task automatic read_word(input logic [13:0] addr, output logic [48:0] w);
      logic [31:0] lo;
      logic [31:0] hi;
      wb_write(ucode_pkg::REG_ADDR, {18'd0, addr});
      wb_read(ucode_pkg::REG_DATA_LO, lo);
      wb_read(ucode_pkg::REG_DATA_HI, hi);
      w = {hi[16:0], lo};
   endtask

   ////////////////////////////////////////
   // Word builders and reference model.
   ////////////////////////////////////////

   // Random fields; halt in bit 48, op in bits 47..46.
   function automatic logic [48:0] alu_word(input logic halt, input logic [1:0] op);
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      r[48]    = halt;
      r[47:46] = op;
      return r[48:0];
   endfunction

   // Invert in bit 45, target in 44..31, dispatch base in 30..21.
   function automatic logic [48:0] ctrl_word(input logic [1:0] op, input logic invert,
                                             input logic [13:0] target,
                                             input logic [9:0] disp_base);
      logic [48:0] w;
      w        = alu_word(1'b0, op);
      w[45]    = invert;
      w[44:31] = target;
      w[30:21] = disp_base;
      return w;
   endfunction

   // Walks the mirror from address 0 with one delay slot behind every branch.
   function automatic void build_expected(input logic c, input logic [3:0] key);
      logic [13:0] cur;
      logic [13:0] nxt;
      logic [13:0] fetch;
      logic [48:0] w;
      cur = 14'd0;
      nxt = 14'd1;
      exp_addr.delete();
      exp_word.delete();
      while (exp_addr.size() < 256) begin
         w = ref_mem[cur];
         exp_addr.push_back(cur);
         exp_word.push_back(w);
         if (w[48]) begin
            return;
         end
         case (w[47:46])
            2'd1: fetch = (c ^ w[45]) ? w[44:31] : nxt + 14'd1;
            2'd2: fetch = {w[30:21], key};
            default: fetch = nxt + 14'd1;
         endcase
         cur = nxt;
         nxt = fetch;
      end
   endfunction

   ////////////////////////////////////////
   // Shown word monitor.
   ////////////////////////////////////////

   always @(negedge clk) begin
      logic [48:0] w;
      logic        alu_type;
      if (ir_valid) begin
         if (exp_addr.size() == 0) begin
            report_failure($sformatf("ir_valid high at %0d ns after the halt was shown",
                                     $time));
         end else begin
            w        = exp_word[0];
            alu_type = (w[47:46] == 2'd0) || (w[47:46] == 2'd3);
            check(64'(pc), 64'(exp_addr[0]), "shown pc");
            check(64'(ir), 64'(w), "shown word");
            // Datapath fields only for ALU-type words.
            check(64'(alu_fn), alu_type ? 64'(w[45:41]) : 64'd0, "alu_fn");
            check(64'(dest), alu_type ? 64'(w[40:29]) : 64'd0, "dest");
            void'(exp_addr.pop_front());
            void'(exp_word.pop_front());
         end
      end
   end

   // Pulses run and returns once the sequencer is running.
   task automatic start_run(input logic c, input logic [3:0] key);
      build_expected(c, key);
      @(posedge clk);
      #1;
      cond     = c;
      disp_key = key;
      run      = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      @(negedge clk);
      while (!running) @(negedge clk);
   endtask

   task automatic finish_run();
      while (running) @(negedge clk);
      check(64'(exp_addr.size()), 64'd0, "words left unshown");
   endtask

   ////////////////////////////////////////
   // Test sequence.
   ////////////////////////////////////////

   initial begin
      logic [48:0] w;
      logic [31:0] d;
      int          i;
      clk      = 1'b0;
      arst_n   = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 4'd0;
      wb_dat_w = 32'd0;
      run      = 1'b0;
      cond     = 1'b0;
      disp_key = 4'd0;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // Reset state.
      check(64'(wb_ack), 64'd0, "wb_ack after reset");
      check(64'(ir_valid), 64'd0, "ir_valid after reset");
      check(64'(running), 64'd0, "running after reset");
      check(64'(pc), 64'd0, "pc after reset");
      wb_read(ucode_pkg::REG_STATUS, d);
      check(64'(d), 64'd0, "status after reset");

      // 32 random words with auto increment, then readback.
      wb_write(ucode_pkg::REG_ADDR, 32'd0);
      for (i = 0; i < 32; i++) begin
         w          = alu_word(1'($random(seed)), 2'($random(seed)));
         ref_mem[i] = w;
         write_data(w);
      end
      for (i = 0; i < 32; i++) begin
         read_word(14'(i), w);
         check(64'(w), 64'(ref_mem[i]), "readback");
      end

      // Straight line ending in halt; one reserved op acts as sequential.
      for (i = 0; i < 6; i++) begin
         load_word(14'(i), alu_word(1'b0, (i == 3) ? 2'd3 : 2'd0));
      end
      load_word(14'd6, alu_word(1'b1, 2'd0));
      start_run(1'b0, 4'd0);
      finish_run();
      wb_read(ucode_pkg::REG_STATUS, d);
      check(64'(d), 64'd6, "status after straight line");

      // Jumps to 20 over all cond and invert pairs.
      load_word(14'd0, alu_word(1'b0, 2'd0));
      load_word(14'd2, alu_word(1'b0, 2'd0));
      load_word(14'd3, alu_word(1'b0, 2'd0));
      load_word(14'd4, alu_word(1'b1, 2'd0));
      load_word(14'd20, alu_word(1'b0, 2'd0));
      load_word(14'd21, alu_word(1'b1, 2'd0));
      for (i = 0; i < 4; i++) begin
         load_word(14'd1, ctrl_word(2'd1, i[1], 14'd20, 10'd0));
         start_run(i[0], 4'd0);
         finish_run();
      end

      // Dispatch with base 5, so targets sit at 80 plus the key.
      load_word(14'd1, ctrl_word(2'd2, 1'b0, 14'd0, 10'd5));
      load_word(14'd3, alu_word(1'b1, 2'd0));
      for (i = 0; i < 4; i++) begin
         load_word(14'(80 + i * 5), alu_word(1'b0, 2'd0));
         load_word(14'(81 + i * 5), alu_word(1'b1, 2'd0));
         start_run(1'($random(seed)), 4'(i * 5));
         finish_run();
      end

      // DATA_HI write issued while running waits for the halt.
      wb_write(ucode_pkg::REG_ADDR, 32'd0);
      for (i = 0; i < 20; i++) begin
         w          = alu_word(i == 19, 2'd0);
         ref_mem[i] = w;
         write_data(w);
      end
      w = alu_word(1'b0, 2'd1);
      wb_write(ucode_pkg::REG_ADDR, 32'd200);
      wb_write(ucode_pkg::REG_DATA_LO, w[31:0]);
      start_run(1'b0, 4'd0);
      wb_write(ucode_pkg::REG_DATA_HI, {15'd0, w[48:32]});
      check(64'(running), 64'd0, "running at held write ack");
      check(64'(exp_addr.size()), 64'd0, "words left at held write ack");
      ref_mem[200] = w;
      finish_run();
      read_word(14'd200, w);
      check(64'(w), 64'(ref_mem[200]), "readback of held write");

      $display("Result: PASSED");
      $finish;
   end

endmodule

/* ucode_top.sv */
/* Microcode store and fetch unit. Host loads words over Wishbone while halted;
   run starts fetching from address 0. */

module ucode_top #(
   parameter int MEM_DEPTH = 16384
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   // Wishbone classic slave.
   input  logic                                 wb_cyc,
   input  logic                                 wb_stb,
   input  logic                                 wb_we,
   input  logic [3:0]                           wb_adr,
   input  logic [31:0]                          wb_dat_w,
   output logic [31:0]                          wb_dat_r,
   output logic                                 wb_ack,
   // Stand-ins for the datapath.
   input  logic                                 run,
   input  logic                                 cond,
   input  logic [ucode_pkg::DISP_KEY_WIDTH-1:0] disp_key,
   // Fetch status.
   output logic [ucode_pkg::IR_WIDTH-1:0]       ir,
   output logic                                 ir_valid,
   output logic [ucode_pkg::PC_WIDTH-1:0]       pc,
   output logic                                 running,
   output logic [4:0]                           alu_fn,
   output logic [11:0]                          dest
);

   // Loader to sequencer, then sequencer to RAM.
   iram_port_if load_port ();
   iram_port_if ram_port ();

   ucode_loader ucode_loader_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .running  (running),
      .pc       (pc),
      .port     (load_port.loader)
   );

   usequencer #(
      .MEM_DEPTH (MEM_DEPTH)
   ) usequencer_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .run      (run),
      .cond     (cond),
      .disp_key (disp_key),
      .load     (load_port.arbiter),
      .ram      (ram_port.master),
      .ir       (ir),
      .ir_valid (ir_valid),
      .pc       (pc),
      .running  (running),
      .alu_fn   (alu_fn),
      .dest     (dest)
   );

   iram #(
      .MEM_DEPTH (MEM_DEPTH)
   ) iram_i (
      .clk  (clk),
      .port (ram_port.ram)
   );

endmodule

/* usequencer.sv */
/* Microsequencer. Fetches one word per cycle with a single delay slot.
   Owns the RAM port and grants it to the loader while halted. */

module usequencer #(
   parameter int MEM_DEPTH = 16384
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 run,
   input  logic                                 cond,
   input  logic [ucode_pkg::DISP_KEY_WIDTH-1:0] disp_key,
   iram_port_if.arbiter                         load,
   iram_port_if.master                          ram,
   output logic [ucode_pkg::IR_WIDTH-1:0]       ir,
   output logic                                 ir_valid,
   output logic [ucode_pkg::PC_WIDTH-1:0]       pc,
   output logic                                 running,
   output logic [4:0]                           alu_fn,
   output logic [11:0]                          dest
);

   localparam int PC_WIDTH = ucode_pkg::PC_WIDTH;

   logic                 run_q;
   logic                 run_rise;
   logic [PC_WIDTH-1:0]  fetch_pc;
   logic [PC_WIDTH-1:0]  seq_pc;
   logic [PC_WIDTH-1:0]  target;
   logic [PC_WIDTH-1:0]  next_pc;
   logic                 taken;
   logic                 halt_now;
   logic                 alu_type;
   ucode_pkg::uinst_u    word;

   ////////////////////////////////////////
   // RAM port routing.
   ////////////////////////////////////////

   // Fetch owns the RAM while running.
   always_comb begin
      if (running) begin
         ram.req = 1'b1;
         ram.addr = fetch_pc;
         ram.we = 1'b0;
      end else begin
         ram.req = load.req;
         ram.addr = load.addr;
         ram.we = load.we;
      end
   end

   // Write data only matters when the loader has the port.
   assign ram.wdata  = load.wdata;
   assign load.rdata = ram.rdata;

   // Loader drops req after one grant.
   assign load.gnt = load.req & ~running;

   ////////////////////////////////////////
   // Decode of the shown word.
   ////////////////////////////////////////

   assign ir   = ram.rdata;
   assign word = ram.rdata;

   assign run_rise = run & ~run_q;
   assign halt_now = ir_valid & word.alu_view.halt;

   always_comb begin
      taken  = 1'b0;
      target = word.jump_view.target;
      case (word.jump_view.op)
         ucode_pkg::op_jump: begin
            taken = cond ^ word.jump_view.invert;
         end
         ucode_pkg::op_dispatch: begin
            taken  = 1'b1;
            target = {word.jump_view.disp_base, disp_key};
         end
         default: begin
            taken = 1'b0;
         end
      endcase
   end

   // Sequential step wraps at the top of the store.
   assign seq_pc = (fetch_pc == PC_WIDTH'(MEM_DEPTH - 1)) ? '0 : fetch_pc + 1'b1;

   // The slot behind a branch is already in flight, so it becomes the delay slot.
   assign next_pc = (ir_valid && taken) ? target : seq_pc;

   // Datapath fields only for ALU-type words on show.
   assign alu_type = (word.alu_view.op == ucode_pkg::op_alu) |
                     (word.alu_view.op == ucode_pkg::op_rsvd);
   assign alu_fn   = (ir_valid && alu_type) ? word.alu_view.alu_fn : '0;
   assign dest     = (ir_valid && alu_type) ? word.alu_view.dest : '0;

   ////////////////////////////////////////
   // Run control and fetch address.
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run_q    <= 1'b0;
         running  <= 1'b0;
         ir_valid <= 1'b0;
         fetch_pc <= '0;
         pc       <= '0;
      end else begin
         run_q <= run;
         if (!running) begin
            // Start presents address 0 in the next cycle.
            if (run_rise) begin
               running  <= 1'b1;
               fetch_pc <= '0;
            end
         end else if (halt_now) begin
            // Word fetched behind the halt is dropped.
            running  <= 1'b0;
            ir_valid <= 1'b0;
         end else begin
            ir_valid <= 1'b1;
            pc       <= fetch_pc;
            fetch_pc <= next_pc;
         end
      end
   end

endmodule

/* ucode_loader.sv */
/* Wishbone classic slave for loading and reading back microcode.
   Four registers; data accesses go to the RAM through req/gnt. */

module ucode_loader (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [3:0]                     wb_adr,
   input  logic [31:0]                    wb_dat_w,
   output logic [31:0]                    wb_dat_r,
   output logic                           wb_ack,
   input  logic                           running,
   input  logic [ucode_pkg::PC_WIDTH-1:0] pc,
   iram_port_if.loader                    port
);

   localparam int PC_WIDTH = ucode_pkg::PC_WIDTH;
   localparam int IR_WIDTH = ucode_pkg::IR_WIDTH;
   // Bits of the word above DATA_LO.
   localparam int HI_BITS  = IR_WIDTH - 32;

   // Access states.
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_REQ   = 2'd1;
   localparam logic [1:0] ST_RDATA = 2'd2;

   logic [1:0]          state;
   logic [PC_WIDTH-1:0] addr_q;
   logic [IR_WIDTH-1:0] stage_q;
   logic                rd_op;
   logic [1:0]          reg_sel;
   logic                wb_start;
   logic                ram_op;

   ////////////////////////////////////////
   // Decode.
   ////////////////////////////////////////

   assign reg_sel = wb_adr[3:2];

   // New cycle seen only when idle and not in the ack cycle.
   assign wb_start = wb_cyc & wb_stb & ~wb_ack & (state == ST_IDLE);

   // DATA_HI write or any data read needs the RAM.
   assign ram_op = (~wb_we & ((reg_sel == ucode_pkg::REG_DATA_LO) |
                              (reg_sel == ucode_pkg::REG_DATA_HI))) |
                   (wb_we & (reg_sel == ucode_pkg::REG_DATA_HI));

   // Request held from ST_REQ until the grant.
   assign port.req   = (state == ST_REQ);
   assign port.addr  = addr_q;
   assign port.wdata = stage_q;
   assign port.we    = ~rd_op;

   ////////////////////////////////////////
   // Control.
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= ST_IDLE;
         wb_ack <= 1'b0;
         rd_op  <= 1'b0;
         addr_q <= '0;
      end else begin
         // Ack is a single-cycle pulse.
         wb_ack <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (wb_start) begin
                  if (ram_op) begin
                     state <= ST_REQ;
                     rd_op <= ~wb_we;
                  end else begin
                     wb_ack <= 1'b1;
                     if (wb_we && (reg_sel == ucode_pkg::REG_ADDR)) begin
                        addr_q <= wb_dat_w[PC_WIDTH-1:0];
                     end
                  end
               end
            end
            ST_REQ: begin
               // Waits here while the sequencer runs.
               if (port.gnt) begin
                  if (rd_op) begin
                     state <= ST_RDATA;
                  end else begin
                     state  <= ST_IDLE;
                     wb_ack <= 1'b1;
                     addr_q <= addr_q + 1'b1;
                  end
               end
            end
            ST_RDATA: begin
               state  <= ST_IDLE;
               wb_ack <= 1'b1;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Staging word and read data.
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wb_start && wb_we) begin
         if (reg_sel == ucode_pkg::REG_DATA_LO) begin
            stage_q[31:0] <= wb_dat_w;
         end
         if (reg_sel == ucode_pkg::REG_DATA_HI) begin
            stage_q[IR_WIDTH-1:32] <= wb_dat_w[HI_BITS-1:0];
         end
      end
      // RAM word lands in the cycle after the grant.
      if (state == ST_RDATA) begin
         stage_q <= port.rdata;
         if (reg_sel == ucode_pkg::REG_DATA_HI) begin
            wb_dat_r <= {{(32 - HI_BITS){1'b0}}, port.rdata[IR_WIDTH-1:32]};
         end else begin
            wb_dat_r <= port.rdata[31:0];
         end
      end
      if (wb_start && !wb_we) begin
         if (reg_sel == ucode_pkg::REG_ADDR) begin
            wb_dat_r <= {{(32 - PC_WIDTH){1'b0}}, addr_q};
         end
         // Running in bit 16, pc in the low bits.
         if (reg_sel == ucode_pkg::REG_STATUS) begin
            wb_dat_r <= {15'd0, running, {(16 - PC_WIDTH){1'b0}}, pc};
         end
      end
   end

endmodule

/* iram.sv */
/* Microcode store. Synchronous single port, read-first, one cycle read latency.
   Inferred array, no vendor primitive. */

module iram #(
   parameter int MEM_DEPTH = 16384
) (
   input logic      clk,
   iram_port_if.ram port
);

   ////////////////////////////////////////
   // Storage.
   ////////////////////////////////////////

   // No reset on the array or the read register.
   logic [ucode_pkg::IR_WIDTH-1:0] mem [MEM_DEPTH];

   ////////////////////////////////////////
   // Access.
   ////////////////////////////////////////

   // Old contents come out on a write cycle.
   // rdata holds while the port is idle.
   always_ff @(posedge clk) begin
      if (port.req) begin
         if (port.we) begin
            mem[port.addr] <= port.wdata;
         end
         port.rdata <= mem[port.addr];
      end
   end

endmodule

/* iram_port_if.sv */
/* Single RAM port shared by loader, sequencer and RAM.
   Loader side uses req/gnt; the RAM side uses req as its enable. */

interface iram_port_if;

   // Request, or RAM enable on the RAM-side instance.
   logic                               req;
   // One-cycle grant back to the loader.
   logic                               gnt;
   logic [ucode_pkg::PC_WIDTH-1:0]     addr;
   logic [ucode_pkg::IR_WIDTH-1:0]     wdata;
   logic                               we;
   // Valid the cycle after the access.
   logic [ucode_pkg::IR_WIDTH-1:0]     rdata;

   // Host loader asking for the port.
   modport loader (output req, addr, wdata, we, input gnt, rdata);

   // Sequencer granting the loader.
   modport arbiter (input req, addr, wdata, we, output gnt, rdata);

   // Sequencer driving the RAM.
   modport master (output req, addr, wdata, we, input rdata);

   // The RAM itself.
   modport ram (input req, addr, wdata, we, output rdata);

endinterface

/* ucode_pkg.sv */
/* Shared widths, op codes, register offsets and the microinstruction layout.
   Every design file refers to these by scoped name. */

package ucode_pkg;

   // Microinstruction and microcode address widths.
   localparam int IR_WIDTH       = 49;
   localparam int PC_WIDTH       = 14;
   localparam int DISP_KEY_WIDTH = 4;

   // Host register word offsets, taken from adr bits 3..2.
   localparam logic [1:0] REG_ADDR    = 2'd0;
   localparam logic [1:0] REG_DATA_LO = 2'd1;
   localparam logic [1:0] REG_DATA_HI = 2'd2;
   localparam logic [1:0] REG_STATUS  = 2'd3;

   // Op type field. Reserved behaves as sequential.
   typedef enum logic [1:0] {
      op_alu      = 2'd0,
      op_jump     = 2'd1,
      op_dispatch = 2'd2,
      op_rsvd     = 2'd3
   } op_e;

   // Word as seen by the datapath.
   typedef struct packed {
      logic        halt;
      op_e         op;
      logic [4:0]  alu_fn;
      logic [11:0] dest;
      logic [5:0]  m_src;
      logic [13:0] a_src;
      logic [8:0]  spare;
   } alu_view_t;

   // Word as seen by the sequencer for jumps and dispatches.
   typedef struct packed {
      logic        halt;
      op_e         op;
      logic        invert;
      logic [13:0] target;
      logic [9:0]  disp_base;
      logic [20:0] spare;
   } jump_view_t;

   // Halt and op sit in the same bits in both views.
   typedef union packed {
      alu_view_t  alu_view;
      jump_view_t jump_view;
   } uinst_u;

endpackage
